/* frontend.f */
+incdir+rtl
rtl/fe_stream_pkg.sv
rtl/fe_codec_pkg.sv
rtl/group_if.sv
rtl/group_offsets.sv
rtl/word_expander.sv
rtl/group_decoder.sv
rtl/frontend_ctrl.sv
rtl/frontend_top.sv
sim/tb_frontend.sv

/* rtl/fe_codec_pkg.sv */
`default_nettype none
`include "fe_params.svh"

package fe_codec_pkg;

    // Word length carried by each 2-bit bitmap code
    typedef enum logic [1:0] {
        code_zero   = 2'b00,
        code_byte   = 2'b01,
        code_half   = 2'b10,
        code_triple = 2'b11
    } fe_code_e;

    typedef logic [`FE_LANE_W-1:0] lane_word_t;

    typedef logic [9:0] lane_offset_t;  // Bit position inside a group

    typedef logic [9:0] cursor_t;  // Bit position inside the two-beat window

endpackage

`default_nettype wire

/* rtl/fe_params.svh */
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

`define FE_DATA_W           256
`define FE_KEEP_W           32
`define FE_LANES            8
`define FE_LANE_W           32
`define FE_BITMAP_W         16

`define FE_HDR_BEATS        4
`define FE_FRAME_BEATS      48
`define FE_LAST_KEEP_BYTES  10

`define FE_FRAME_LEN        1514
`define FE_ETH_HDR_LEN      14

`define FE_TOS_A            8'h28
`define FE_TOS_B            8'h20

`endif

/* rtl/fe_stream_pkg.sv */
`default_nettype none
`include "fe_params.svh"

package fe_stream_pkg;

    typedef struct packed {
        logic [111:0] pad_hi;
        logic [7:0]   len_lo;  // IP total length, low byte
        logic [7:0]   len_hi;
        logic [7:0]   tos;     // IP type of service
        logic [119:0] pad_lo;  // Ethernet header and first IP byte
    } fe_hdr_s;

    typedef union packed {
        logic [`FE_DATA_W-1:0] raw;
        fe_hdr_s               hdr;
    } fe_beat_u;

    typedef enum logic [2:0] {
        st_idle,
        st_bypass,
        st_header,
        st_decode,
        st_drain
    } fe_state_e;

endpackage

`default_nettype wire

/* rtl/frontend_ctrl.sv */
`default_nettype none
`include "fe_params.svh"

module frontend_ctrl (
    input  wire logic                  aclk,
    input  wire logic                  aresetn,
    input  wire logic [`FE_DATA_W-1:0] axis_tdata,
    input  wire logic [`FE_KEEP_W-1:0] axis_tkeep,
    input  wire logic                  axis_tvalid,
    input  wire logic                  axis_tlast,
    output logic                       axis_tready,
    output logic [`FE_DATA_W-1:0]      dma_tdata,
    output logic [`FE_KEEP_W-1:0]      dma_tkeep,
    output logic                       dma_tvalid,
    output logic                       dma_tlast,
    input  wire logic                  dma_tready,
    output logic                       need_decomp,
    group_if.ctrl                      grp
);
    import fe_stream_pkg::*;

    localparam logic [`FE_KEEP_W-1:0] last_keep = (1 << `FE_LAST_KEEP_BYTES) - 1;

    fe_state_e   state;
    fe_beat_u    first_beat;
    logic [15:0] ip_len;
    logic        tos_hit;
    logic        mark;
    logic        out_free;
    logic        in_fire;
    logic        seen_last;
    logic        last_now;
    logic        pending;
    logic        active;
    logic [5:0]  beat_cnt;
    logic        final_beat;

    assign first_beat.raw = axis_tdata;
    assign ip_len = {first_beat.hdr.len_hi, first_beat.hdr.len_lo};
    assign tos_hit = (first_beat.hdr.tos == `FE_TOS_A) || (first_beat.hdr.tos == `FE_TOS_B);
    assign mark = tos_hit && (ip_len + 16'(`FE_ETH_HDR_LEN) == 16'(`FE_FRAME_LEN));

    assign out_free = !dma_tvalid || dma_tready;
    assign in_fire = axis_tvalid && axis_tready;
    assign last_now = seen_last || (in_fire && axis_tlast);
    assign final_beat = (beat_cnt == 6'(`FE_FRAME_BEATS - 1));

    always_comb begin
        axis_tready = 1'b0;
        grp.beat = '0;
        grp.load = 1'b0;
        grp.start = 1'b0;
        grp.flush = 1'b0;
        case (state)
            st_idle: begin
                axis_tready = active && out_free;
                grp.flush = axis_tvalid && active && out_free && mark;
            end
            st_bypass, st_header: begin
                axis_tready = out_free;
            end
            st_decode: begin
                if (grp.need_beat) begin
                    axis_tready = !seen_last;
                    grp.load = seen_last || axis_tvalid;  // Zeros once the packet has ended
                    grp.beat = seen_last ? '0 : axis_tdata;
                end
                grp.start = grp.group_ready && !pending && out_free;
            end
            default: begin
                axis_tready = 1'b1;  // Discard leftover compressed input
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= st_idle;
            dma_tvalid <= 1'b0;
            need_decomp <= 1'b0;
            beat_cnt <= '0;
            seen_last <= 1'b0;
            pending <= 1'b0;
            active <= 1'b0;
        end else begin
            active <= 1'b1;
            if (dma_tready) begin
                dma_tvalid <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (in_fire) begin
                        dma_tvalid <= 1'b1;
                        need_decomp <= mark;
                        seen_last <= axis_tlast;
                        beat_cnt <= 6'd1;
                        if (mark) begin
                            state <= axis_tlast ? st_decode : st_header;
                        end else if (!axis_tlast) begin
                            state <= st_bypass;
                        end
                    end
                end
                st_bypass: begin
                    if (in_fire) begin
                        dma_tvalid <= 1'b1;
                        if (axis_tlast) begin
                            state <= st_idle;
                        end
                    end
                end
                st_header: begin
                    if (in_fire) begin
                        dma_tvalid <= 1'b1;
                        beat_cnt <= beat_cnt + 6'd1;
                        seen_last <= axis_tlast;
                        if (axis_tlast || beat_cnt == 6'(`FE_HDR_BEATS - 1)) begin
                            state <= st_decode;
                        end
                    end
                end
                st_decode: begin
                    seen_last <= last_now;
                    if (grp.start) begin
                        pending <= 1'b1;
                    end
                    if (grp.done) begin
                        pending <= 1'b0;
                        dma_tvalid <= 1'b1;
                        beat_cnt <= beat_cnt + 6'd1;
                        if (final_beat) begin
                            state <= last_now ? st_idle : st_drain;
                        end
                    end
                end
                default: begin
                    if (in_fire && axis_tlast) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == st_decode) begin
            if (grp.done) begin
                dma_tdata <= grp.result;
                dma_tkeep <= final_beat ? last_keep : '1;
                dma_tlast <= final_beat;
            end
        end else if (in_fire && state != st_drain) begin
            dma_tdata <= axis_tdata;
            dma_tkeep <= axis_tkeep;
            // A marked frame ends on its last decoded beat
            dma_tlast <= axis_tlast && (state == st_bypass || (state == st_idle && !mark));
        end
    end

endmodule

`default_nettype wire

/* rtl/frontend_top.sv */
`default_nettype none
`include "fe_params.svh"

module frontend_top (
    input  wire logic                  aclk,
    input  wire logic                  aresetn,

    input  wire logic [`FE_DATA_W-1:0] axis_tdata,
    input  wire logic [`FE_KEEP_W-1:0] axis_tkeep,
    input  wire logic                  axis_tvalid,
    input  wire logic                  axis_tlast,
    output logic                       axis_tready,

    output logic [`FE_DATA_W-1:0]      dma_tdata,
    output logic [`FE_KEEP_W-1:0]      dma_tkeep,
    output logic                       dma_tvalid,
    output logic                       dma_tlast,
    input  wire logic                  dma_tready,

    output logic                       need_decomp
);

    group_if u_group_if ();

    frontend_ctrl u_ctrl (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .axis_tdata  (axis_tdata),
        .axis_tkeep  (axis_tkeep),
        .axis_tvalid (axis_tvalid),
        .axis_tlast  (axis_tlast),
        .axis_tready (axis_tready),
        .dma_tdata   (dma_tdata),
        .dma_tkeep   (dma_tkeep),
        .dma_tvalid  (dma_tvalid),
        .dma_tlast   (dma_tlast),
        .dma_tready  (dma_tready),
        .need_decomp (need_decomp),
        .grp         (u_group_if.ctrl)
    );

    // One group in flight at a time since each start depends on the last length
    group_decoder u_decoder (
        .aclk    (aclk),
        .aresetn (aresetn),
        .grp     (u_group_if.dec)
    );

endmodule

`default_nettype wire

/* rtl/group_decoder.sv */
`default_nettype none
`include "fe_params.svh"

module group_decoder (
    input wire logic aclk,
    input wire logic aresetn,
    group_if.dec     grp
);
    import fe_codec_pkg::*;

    logic [`FE_DATA_W-1:0]   win_lo;
    logic [`FE_DATA_W-1:0]   win_hi;
    logic [2*`FE_DATA_W-1:0] window;
    logic [1:0]              win_cnt;
    logic [1:0]              win_cnt_n;
    cursor_t                 cursor;
    cursor_t                 cursor_n;
    logic                    drop;
    logic [3:0]              stage;
    logic [3:0]              stage_n;
    logic [`FE_BITMAP_W-1:0] bitmap;
    lane_offset_t            offsets [`FE_LANES];
    lane_offset_t            group_len;
    lane_offset_t            lane_pos [`FE_LANES];
    lane_word_t              slice_q [`FE_LANES];
    lane_word_t              words [`FE_LANES];

    assign window = {win_hi, win_lo};
    assign drop = (win_cnt == 2'd2) && (cursor >= cursor_t'(`FE_DATA_W));
    assign stage_n = {stage[2:0], grp.start};  // One bit per pipeline step of the group

    always_comb begin
        for (int i = 0; i < `FE_LANES; i++) begin
            lane_pos[i] = cursor + lane_offset_t'(`FE_BITMAP_W) + offsets[i];
        end
    end

    always_comb begin
        win_cnt_n = win_cnt;
        cursor_n = cursor;
        if (grp.flush) begin
            win_cnt_n = 2'd0;
            cursor_n = '0;
        end else if (grp.load) begin
            win_cnt_n = win_cnt + 2'd1;
        end else if (drop) begin
            win_cnt_n = 2'd1;
            cursor_n = cursor - cursor_t'(`FE_DATA_W);
        end
        if (stage[2]) begin
            cursor_n = cursor + cursor_t'(`FE_BITMAP_W) + group_len;  // Skip bitmap and words
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            win_cnt <= '0;
            cursor <= '0;
            stage <= '0;
            grp.done <= 1'b0;
            grp.need_beat <= 1'b0;
            grp.group_ready <= 1'b0;
        end else begin
            win_cnt <= win_cnt_n;
            cursor <= cursor_n;
            stage <= stage_n;
            grp.done <= stage[3];
            grp.need_beat <= (win_cnt_n != 2'd2);
            grp.group_ready <= (win_cnt_n == 2'd2) && (cursor_n < cursor_t'(`FE_DATA_W))
                               && (stage_n == '0);
        end
    end

    always_ff @(posedge aclk) begin
        if (grp.load) begin
            if (win_cnt == 2'd0) begin
                win_lo <= grp.beat;
            end else begin
                win_hi <= grp.beat;
            end
        end else if (drop) begin
            win_lo <= win_hi;  // Low beat fully consumed
        end
        if (grp.start) begin
            bitmap <= `FE_BITMAP_W'(window >> cursor);
        end
        if (stage[2]) begin
            for (int i = 0; i < `FE_LANES; i++) begin
                slice_q[i] <= lane_word_t'(window >> lane_pos[i]);
            end
        end
        if (stage[3]) begin
            for (int i = 0; i < `FE_LANES; i++) begin
                grp.result[i*`FE_LANE_W +: `FE_LANE_W] <= words[i];
            end
        end
    end

    group_offsets u_offsets (
        .aclk      (aclk),
        .bitmap    (bitmap),
        .offsets   (offsets),
        .group_len (group_len)
    );

    for (genvar i = 0; i < `FE_LANES; i++) begin : g_lane
        word_expander u_expander (
            .slice (slice_q[i]),
            .code  (fe_code_e'(bitmap[2*i +: 2])),
            .word  (words[i])
        );
    end

endmodule

`default_nettype wire

/* rtl/group_if.sv */
`default_nettype none
`include "fe_params.svh"

interface group_if;

    logic [`FE_DATA_W-1:0] beat;
    logic                  load;
    logic                  flush;
    logic                  start;
    logic                  need_beat;    // Window holds fewer than two beats
    logic                  group_ready;
    logic                  done;
    logic [`FE_DATA_W-1:0] result;       // Valid while done is high

    modport ctrl (
        output beat, load, flush, start,
        input  need_beat, group_ready, done, result
    );

    modport dec (
        input  beat, load, flush, start,
        output need_beat, group_ready, done, result
    );

endinterface

`default_nettype wire

/* rtl/group_offsets.sv */
`default_nettype none
`include "fe_params.svh"

module group_offsets (
    input  wire logic                    aclk,
    input  wire logic [`FE_BITMAP_W-1:0] bitmap,
    output fe_codec_pkg::lane_offset_t   offsets [`FE_LANES],
    output fe_codec_pkg::lane_offset_t   group_len
);
    import fe_codec_pkg::*;

    logic [4:0] len_q [`FE_LANES];

    function automatic logic [4:0] code_len(input fe_code_e code);
        case (code)
            code_byte:   code_len = 5'd8;
            code_half:   code_len = 5'd16;
            code_triple: code_len = 5'd24;
            default:     code_len = 5'd0;
        endcase
    endfunction

    // Stage 1 turns each code into a bit count
    always_ff @(posedge aclk) begin
        for (int i = 0; i < `FE_LANES; i++) begin
            len_q[i] <= code_len(fe_code_e'(bitmap[2*i +: 2]));
        end
    end

    // Stage 2 forms the exclusive prefix sums and the group total
    always_ff @(posedge aclk) begin
        lane_offset_t acc;
        acc = '0;
        for (int i = 0; i < `FE_LANES; i++) begin
            offsets[i] <= acc;
            acc = acc + lane_offset_t'(len_q[i]);
        end
        group_len <= acc;
    end

endmodule

`default_nettype wire

/* rtl/word_expander.sv */
`default_nettype none
`include "fe_params.svh"

module word_expander (
    input  wire fe_codec_pkg::lane_word_t slice,
    input  wire fe_codec_pkg::fe_code_e   code,
    output fe_codec_pkg::lane_word_t      word
);
    import fe_codec_pkg::*;

    always_comb begin
        case (code)
            code_zero: word = '0;
            code_byte: word = {24'd0, slice[7:0]};
            code_half: word = {16'd0, slice[15:0]};
            default:   word = {8'd0, slice[23:0]};  // Longest word is 24 bits
        endcase
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f frontend.f --top-module tb_frontend \
    && ./obj_dir/Vtb_frontend | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }
grep -q '^\*\* PASS \*\*$' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* sim/tb_frontend.sv */
`default_nettype none
`include "fe_params.svh"

module tb_frontend;

    localparam int clk_period = 10;
    localparam int num_packets = 8;
    localparam int max_beats = 64;
    localparam int decoded_beats = `FE_FRAME_BEATS - `FE_HDR_BEATS;
    localparam logic [`FE_KEEP_W-1:0] full_keep = '1;
    localparam logic [`FE_KEEP_W-1:0] last_keep = (32'd1 << `FE_LAST_KEEP_BYTES) - 32'd1;

    logic                  aclk;
    logic                  aresetn;
    logic [`FE_DATA_W-1:0] axis_tdata;
    logic [`FE_KEEP_W-1:0] axis_tkeep;
    logic                  axis_tvalid;
    logic                  axis_tlast;
    logic                  axis_tready;
    logic [`FE_DATA_W-1:0] dma_tdata;
    logic [`FE_KEEP_W-1:0] dma_tkeep;
    logic                  dma_tvalid;
    logic                  dma_tlast;
    logic                  dma_tready;
    logic                  need_decomp;

    integer seed;
    int     value_errors;
    int     other_errors;
    int     checked;
    int     bit_pos;
    int     ready_idx;
    logic   stress;  // Random dma_tready and gaps between input beats
    logic   ready_pat [4096];

    logic [`FE_DATA_W-1:0] in_data [$];
    logic [`FE_KEEP_W-1:0] in_keep [$];
    logic [`FE_DATA_W-1:0] comp [max_beats];  // Compressed bit stream of one marked packet
    logic [`FE_DATA_W-1:0] exp_data [$];
    logic [`FE_KEEP_W+1:0] exp_side [$];      // Packed as {tkeep, tlast, need_decomp}
    string                 exp_name [$];
    int                    exp_idx [$];

    frontend_top u_dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .axis_tdata  (axis_tdata),
        .axis_tkeep  (axis_tkeep),
        .axis_tvalid (axis_tvalid),
        .axis_tlast  (axis_tlast),
        .axis_tready (axis_tready),
        .dma_tdata   (dma_tdata),
        .dma_tkeep   (dma_tkeep),
        .dma_tvalid  (dma_tvalid),
        .dma_tlast   (dma_tlast),
        .dma_tready  (dma_tready),
        .need_decomp (need_decomp)
    );

    initial begin
        aclk = 1'b0;
        forever #(clk_period / 2) aclk = ~aclk;
    end

    initial begin
        #(num_packets * `FE_FRAME_BEATS * 20 * clk_period);
        $display("Watchdog expired before every expected output beat was seen");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        dma_tready = 1'b0;
        ready_idx = 0;
        forever begin
            @(posedge aclk);
            #1;
            if (stress) begin
                dma_tready = ready_pat[ready_idx % 4096];
                ready_idx++;
            end else begin
                dma_tready = 1'b1;
            end
        end
    end

    // A beat seen with valid and ready at the falling edge transfers on the next rising edge
    always @(negedge aclk) begin
        if (aresetn && dma_tvalid && dma_tready) begin
            beat_expected: assert (exp_data.size() != 0) else begin
                other_errors++;
                $display("Output beat arrived when no further beat was expected");
            end
            if (exp_data.size() != 0) begin
                data_match: assert (dma_tdata === exp_data[0]) else begin
                    value_errors++;
                    $display("FAIL %s beat %0d tdata expected %h actual %h",
                             exp_name[0], exp_idx[0], exp_data[0], dma_tdata);
                end
                side_match: assert ({dma_tkeep, dma_tlast, need_decomp} === exp_side[0]) else begin
                    value_errors++;
                    $display("FAIL %s beat %0d tkeep/tlast/need_decomp expected %h actual %h",
                             exp_name[0], exp_idx[0], exp_side[0],
                             {dma_tkeep, dma_tlast, need_decomp});
                end
                void'(exp_data.pop_front());
                void'(exp_side.pop_front());
                void'(exp_name.pop_front());
                void'(exp_idx.pop_front());
                checked++;
            end
        end
    end

    function automatic logic [`FE_DATA_W-1:0] random_beat();
        logic [`FE_DATA_W-1:0] r;
        for (int i = 0; i < `FE_DATA_W / 32; i++) begin
            r[32*i +: 32] = $random(seed);
        end
        return r;
    endfunction

    function automatic logic [`FE_DATA_W-1:0] header_beat(input logic [7:0] tos,
                                                          input logic [15:0] ip_len);
        logic [`FE_DATA_W-1:0] r;
        r = random_beat();
        r[127:120] = tos;
        r[135:128] = ip_len[15:8];
        r[143:136] = ip_len[7:0];
        return r;
    endfunction

    task automatic push_expect(input string name, input int idx,
                               input logic [`FE_DATA_W-1:0] data,
                               input logic [`FE_KEEP_W-1:0] keep,
                               input logic last, input logic mark);
        exp_name.push_back(name);
        exp_idx.push_back(idx);
        exp_data.push_back(data);
        exp_side.push_back({keep, last, mark});
    endtask

    // Bits go in from the least significant end of each beat
    task automatic put_bits(input logic [31:0] value, input int nbits);
        for (int b = 0; b < nbits; b++) begin
            comp[bit_pos / `FE_DATA_W][bit_pos % `FE_DATA_W] = value[b];
            bit_pos++;
        end
    endtask

    task automatic drive_beats();
        logic accepted;
        int   gap;
        for (int i = 0; i < in_data.size(); i++) begin
            gap = stress ? ($random(seed) & 3) : 0;
            repeat (gap) begin
                axis_tvalid = 1'b0;
                @(posedge aclk);
                #1;
            end
            axis_tdata = in_data[i];
            axis_tkeep = in_keep[i];
            axis_tlast = (i == in_data.size() - 1);
            axis_tvalid = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge aclk);
                accepted = axis_tready;
                @(posedge aclk);
                #1;
            end
        end
        axis_tvalid = 1'b0;
        axis_tlast = 1'b0;
    endtask

    task automatic bypass_packet(input string name, input logic [7:0] tos,
                                 input logic [15:0] ip_len, input int beats);
        logic [`FE_DATA_W-1:0] beat;
        logic [`FE_KEEP_W-1:0] keep;
        in_data.delete();
        in_keep.delete();
        for (int i = 0; i < beats; i++) begin
            beat = (i == 0) ? header_beat(tos, ip_len) : random_beat();
            keep = (i == beats - 1) ? (full_keep >> ($random(seed) & 31)) : full_keep;
            in_data.push_back(beat);
            in_keep.push_back(keep);
            push_expect(name, i, beat, keep, i == beats - 1, 1'b0);
        end
        drive_beats();
    endtask

    // Groups beyond the given count see only zeros and so expand to zero beats
    task automatic marked_packet(input string name, input int groups, input int extra);
        logic [`FE_DATA_W-1:0] beat;
        logic [15:0]           bitmap;
        logic [31:0]           words [`FE_LANES];
        int                    len;
        in_data.delete();
        in_keep.delete();
        for (int i = 0; i < `FE_HDR_BEATS; i++) begin
            beat = (i == 0) ? header_beat(`FE_TOS_B, 16'd1500) : random_beat();
            in_data.push_back(beat);
            in_keep.push_back(full_keep);
            push_expect(name, i, beat, full_keep, 1'b0, 1'b1);
        end
        for (int b = 0; b < max_beats; b++) begin
            comp[b] = '0;
        end
        bit_pos = 0;
        for (int g = 0; g < decoded_beats; g++) begin
            beat = '0;
            if (g < groups) begin
                for (int l = 0; l < `FE_LANES; l++) begin
                    bitmap[2*l +: 2] = 2'($random(seed));
                    len = 8 * int'(bitmap[2*l +: 2]);
                    words[l] = $random(seed) & ((32'd1 << len) - 32'd1);
                    beat[32*l +: 32] = words[l];
                end
                put_bits(32'(bitmap), `FE_BITMAP_W);
                for (int l = 0; l < `FE_LANES; l++) begin
                    put_bits(words[l], 8 * int'(bitmap[2*l +: 2]));
                end
            end
            push_expect(name, g + `FE_HDR_BEATS, beat,
                        (g == decoded_beats - 1) ? last_keep : full_keep,
                        g == decoded_beats - 1, 1'b1);
        end
        for (int b = 0; b < (bit_pos + `FE_DATA_W - 1) / `FE_DATA_W; b++) begin
            in_data.push_back(comp[b]);
            in_keep.push_back(full_keep);
        end
        repeat (extra) begin
            in_data.push_back(random_beat());
            in_keep.push_back(full_keep);
        end
        drive_beats();
    endtask

    task automatic wait_outputs();
        while (exp_data.size() != 0) begin
            @(posedge aclk);
        end
        #1;
    endtask

    task automatic set_stress(input logic on);
        wait_outputs();
        @(negedge aclk);
        stress = on;
        @(posedge aclk);
        #1;
    endtask

    task automatic check_reset_state();
        reset_quiet: assert (!dma_tvalid && !need_decomp && !axis_tready) else begin
            other_errors++;
            $display("Outputs were not idle while aresetn was low at time %0t", $time);
        end
    endtask

    initial begin
        seed = 32'hf4e9bf2d;
        value_errors = 0;
        other_errors = 0;
        checked = 0;
        stress = 1'b0;
        aresetn = 1'b0;
        axis_tdata = '0;
        axis_tkeep = '0;
        axis_tvalid = 1'b0;
        axis_tlast = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            ready_pat[i] = ($random(seed) & 3) != 0;
        end
        @(posedge aclk);
        for (int c = 1; c < 10; c++) begin
            @(negedge aclk);
            check_reset_state();
            @(posedge aclk);
        end
        #1;
        aresetn = 1'b1;

        bypass_packet("bypass_tos", 8'h45, 16'd1500, 5);
        bypass_packet("bypass_len", `FE_TOS_A, 16'd1000, 3);
        marked_packet("decomp", decoded_beats, 0);
        set_stress(1'b1);
        bypass_packet("stress_bypass", 8'h00, 16'd1500, 6);
        marked_packet("stress_decomp", decoded_beats, 0);
        set_stress(1'b0);
        marked_packet("short_input", 10, 0);
        marked_packet("extra_input", decoded_beats, 3);  // Leftover beats are drained
        bypass_packet("after_drain", 8'h10, 16'd64, 2);

        wait_outputs();
        repeat (20) @(posedge aclk);
        $display("Beats checked %0d, value errors %0d, other errors %0d",
                 checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
